/* Bender.yml */
package:
  name: adv7513_init

export_include_dirs:
  - .

sources:
  - adv7513_pkg.sv
  - i2c_cmd_if.sv
  - init_table.sv
  - init_step_counter.sv
  - init_fsm.sv
  - i2c_credit_port.sv
  - adv7513_init_top.sv
  - target: simulation
    files:
      - tb_adv7513_init.sv

/* adv7513_config.svh */
`ifndef ADV7513_CONFIG_SVH
`define ADV7513_CONFIG_SVH

// 7-bit I2C address of the HDMI transmitter
`define ADV_CHIP_ADDR 7'h39

// number of register writes in one configuration pass
`define ADV_TABLE_LEN 24

// PLL status register and the position of its lock flag
`define ADV_PLL_REG 8'h9E
`define ADV_PLL_LOCK_BIT 4

// ORed into register 0x17
// 8'h00 keeps 4:3, 8'h02 selects 16:9
`define ADV_ASPECT_R 8'h00

// commands the I2C engine accepts before it must answer
`define ADV_CMD_CREDITS 1

`endif

/* adv7513_init_top.sv */
`timescale 1ns/1ps

module adv7513_init_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      hdmi_int,
    output logic                      cmd_valid,
    output logic                      cmd_is_read,
    output adv7513_pkg::chip_addr_t   cmd_chip_addr,
    output adv7513_pkg::reg_addr_t    cmd_reg_addr,
    output adv7513_pkg::reg_data_t    cmd_value,
    input  logic                      resp_valid,
    input  adv7513_pkg::reg_data_t    resp_data,
    input  logic                      resp_ack_error,
    output logic                      ready,
    output adv7513_pkg::err_count_t   pll_errors
);

    adv7513_pkg::step_t     step;
    logic                   last_step;
    adv7513_pkg::reg_addr_t write_reg;
    adv7513_pkg::reg_data_t write_value;
    logic                   step_clear;
    logic                   step_advance;
    logic                   pll_fail;

    i2c_cmd_if cmd_bus ();

    init_table i_init_table (
        .step     (step),
        .reg_addr (write_reg),
        .value    (write_value)
    );

    init_step_counter i_init_step_counter (
        .clk          (clk),
        .reset        (reset),
        .step_clear   (step_clear),
        .step_advance (step_advance),
        .pll_fail     (pll_fail),
        .step         (step),
        .last_step    (last_step),
        .pll_errors   (pll_errors)
    );

    init_fsm i_init_fsm (
        .clk          (clk),
        .reset        (reset),
        .hdmi_int     (hdmi_int),
        .cmd          (cmd_bus.fsm),
        .step         (step),
        .last_step    (last_step),
        .write_reg    (write_reg),
        .write_value  (write_value),
        .step_clear   (step_clear),
        .step_advance (step_advance),
        .pll_fail     (pll_fail),
        .ready        (ready)
    );

    i2c_credit_port i_i2c_credit_port (
        .clk            (clk),
        .reset          (reset),
        .cmd            (cmd_bus.port),
        .cmd_valid      (cmd_valid),
        .cmd_is_read    (cmd_is_read),
        .cmd_chip_addr  (cmd_chip_addr),
        .cmd_reg_addr   (cmd_reg_addr),
        .cmd_value      (cmd_value),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .resp_ack_error (resp_ack_error)
    );

endmodule

/* adv7513_pkg.sv */
package adv7513_pkg;

    // I2C device address, 7 bits without the r/w bit
    typedef logic [6:0] chip_addr_t;

    // register address inside the transmitter
    typedef logic [7:0] reg_addr_t;

    // register value, also used for read data
    typedef logic [7:0] reg_data_t;

    // position inside the write table
    typedef logic [4:0] step_t;

    // failed PLL lock checks, saturating
    typedef logic [7:0] err_count_t;

    // outstanding command credits
    typedef logic [1:0] credit_t;

    // configuration sequencer states
    typedef enum logic [2:0] {
        st_issue_write,
        st_wait_write,
        st_issue_pll,
        st_wait_pll,
        st_ready
    } init_state_t;

endpackage

/* all.f */
+incdir+.
adv7513_pkg.sv
i2c_cmd_if.sv
init_table.sv
init_step_counter.sv
init_fsm.sv
i2c_credit_port.sv
adv7513_init_top.sv
tb_adv7513_init.sv

/* i2c_cmd_if.sv */
`timescale 1ns/1ps

interface i2c_cmd_if;

    // command side, from the sequencer
    logic                   req;
    logic                   is_read;
    adv7513_pkg::chip_addr_t chip_addr;
    adv7513_pkg::reg_addr_t  reg_addr;
    adv7513_pkg::reg_data_t  value;

    // status and response side, from the credit port
    logic                   can_send;
    logic                   rsp;
    adv7513_pkg::reg_data_t  rsp_data;
    logic                   rsp_ack_error;

    modport fsm (
        output req, is_read, chip_addr, reg_addr, value,
        input  can_send, rsp, rsp_data, rsp_ack_error
    );

    modport port (
        input  req, is_read, chip_addr, reg_addr, value,
        output can_send, rsp, rsp_data, rsp_ack_error
    );

endinterface

/* i2c_credit_port.sv */
`timescale 1ns/1ps
`include "adv7513_config.svh"

module i2c_credit_port (
    input  logic                    clk,
    input  logic                    reset,
    i2c_cmd_if.port                 cmd,
    output logic                    cmd_valid,
    output logic                    cmd_is_read,
    output adv7513_pkg::chip_addr_t cmd_chip_addr,
    output adv7513_pkg::reg_addr_t  cmd_reg_addr,
    output adv7513_pkg::reg_data_t  cmd_value,
    input  logic                    resp_valid,
    input  adv7513_pkg::reg_data_t  resp_data,
    input  logic                    resp_ack_error
);

    adv7513_pkg::credit_t credits;
    logic                 credit_init;
    logic                 launch;

    assign cmd.can_send = (credits != 2'd0);
    assign launch       = cmd.req && cmd.can_send;

    // initial credits are granted in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!reset) begin
            credit_init <= 1'b0;
            credits     <= '0;
            cmd_valid   <= 1'b0;
            cmd.rsp     <= 1'b0;
        end else begin
            credit_init <= 1'b1;
            cmd_valid   <= launch;
            cmd.rsp     <= resp_valid;
            if (!credit_init) begin
                credits <= adv7513_pkg::credit_t'(`ADV_CMD_CREDITS);
            end else if (launch && !resp_valid) begin
                credits <= credits - 2'd1;
            end else if (!launch && resp_valid) begin
                credits <= credits + 2'd1;
            end
        end
    end

    // outgoing command and captured response
    always_ff @(posedge clk) begin
        if (launch) begin
            cmd_is_read   <= cmd.is_read;
            cmd_chip_addr <= cmd.chip_addr;
            cmd_reg_addr  <= cmd.reg_addr;
            cmd_value     <= cmd.value;
        end
        if (resp_valid) begin
            cmd.rsp_data      <= resp_data;
            cmd.rsp_ack_error <= resp_ack_error;
        end
    end

    property p_credit_limit;
        @(posedge clk) disable iff (!reset)
            credits <= adv7513_pkg::credit_t'(`ADV_CMD_CREDITS);
    endproperty

    a_credit_limit: assert property (p_credit_limit)
        else $error("credit count %0d above the granted amount", credits);

    // a response must belong to a command that is still outstanding
    property p_resp_outstanding;
        @(posedge clk) disable iff (!reset)
            resp_valid |-> credit_init &&
                (credits < adv7513_pkg::credit_t'(`ADV_CMD_CREDITS));
    endproperty

    a_resp_outstanding: assert property (p_resp_outstanding)
        else $error("response received with no command outstanding");

endmodule

/* init_fsm.sv */
`timescale 1ns/1ps
`include "adv7513_config.svh"

module init_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hdmi_int,
    i2c_cmd_if.fsm                 cmd,
    input  adv7513_pkg::step_t     step,
    input  logic                   last_step,
    input  adv7513_pkg::reg_addr_t write_reg,
    input  adv7513_pkg::reg_data_t write_value,
    output logic                   step_clear,
    output logic                   step_advance,
    output logic                   pll_fail,
    output logic                   ready
);

    adv7513_pkg::init_state_t state;
    adv7513_pkg::init_state_t state_next;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= adv7513_pkg::st_issue_write;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next   = state;
        cmd.req      = 1'b0;
        step_clear   = 1'b0;
        step_advance = 1'b0;
        pll_fail     = 1'b0;

        case (state)
            adv7513_pkg::st_issue_write: begin
                // hold here while the engine has the credit
                if (cmd.can_send) begin
                    cmd.req    = 1'b1;
                    state_next = adv7513_pkg::st_wait_write;
                end
            end

            adv7513_pkg::st_wait_write: begin
                if (cmd.rsp) begin
                    if (cmd.rsp_ack_error) begin
                        // no ack, send the same entry again
                        state_next = adv7513_pkg::st_issue_write;
                    end else if (last_step) begin
                        state_next = adv7513_pkg::st_issue_pll;
                    end else begin
                        step_advance = 1'b1;
                        state_next   = adv7513_pkg::st_issue_write;
                    end
                end
            end

            adv7513_pkg::st_issue_pll: begin
                if (cmd.can_send) begin
                    cmd.req    = 1'b1;
                    state_next = adv7513_pkg::st_wait_pll;
                end
            end

            adv7513_pkg::st_wait_pll: begin
                if (cmd.rsp) begin
                    if (cmd.rsp_ack_error) begin
                        state_next = adv7513_pkg::st_issue_pll;
                    end else if (cmd.rsp_data[`ADV_PLL_LOCK_BIT]) begin
                        state_next = adv7513_pkg::st_ready;
                    end else begin
                        // PLL not locked, rewrite the whole table
                        pll_fail   = 1'b1;
                        step_clear = 1'b1;
                        state_next = adv7513_pkg::st_issue_write;
                    end
                end
            end

            adv7513_pkg::st_ready: begin
                // interrupt from the transmitter, e.g. hot plug
                if (!hdmi_int) begin
                    step_clear = 1'b1;
                    state_next = adv7513_pkg::st_issue_write;
                end
            end

            default: begin
                step_clear = 1'b1;
                state_next = adv7513_pkg::st_issue_write;
            end
        endcase
    end

    // command fields, the credit port samples them together with req
    assign cmd.is_read   = (state == adv7513_pkg::st_issue_pll);
    assign cmd.chip_addr = `ADV_CHIP_ADDR;
    assign cmd.reg_addr  = cmd.is_read ? `ADV_PLL_REG : write_reg;
    assign cmd.value     = cmd.is_read ? 8'h00 : write_value;

    assign ready = (state == adv7513_pkg::st_ready);

    // a request needs a credit and lasts a single cycle
    property p_req_with_credit;
        @(posedge clk) disable iff (!reset)
            cmd.req |-> cmd.can_send ##1 !cmd.req;
    endproperty

    a_req_with_credit: assert property (p_req_with_credit)
        else $error("command request without credit or longer than one cycle");

    // the lock check only follows a complete table pass
    property p_pll_after_table;
        @(posedge clk) disable iff (!reset)
            (state == adv7513_pkg::st_issue_pll) |->
                (step == adv7513_pkg::step_t'(`ADV_TABLE_LEN - 1));
    endproperty

    a_pll_after_table: assert property (p_pll_after_table)
        else $error("PLL read issued at step %0d", step);

endmodule

/* init_step_counter.sv */
`timescale 1ns/1ps
`include "adv7513_config.svh"

module init_step_counter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      step_clear,
    input  logic                      step_advance,
    input  logic                      pll_fail,
    output adv7513_pkg::step_t        step,
    output logic                      last_step,
    output adv7513_pkg::err_count_t   pll_errors
);

    // table position, clear wins over advance
    always_ff @(posedge clk) begin
        if (!reset) begin
            step <= '0;
        end else if (step_clear) begin
            step <= '0;
        end else if (step_advance) begin
            step <= step + 5'd1;
        end
    end

    assign last_step = (step == adv7513_pkg::step_t'(`ADV_TABLE_LEN - 1));

    // failed lock checks, held at 255 once reached
    always_ff @(posedge clk) begin
        if (!reset) begin
            pll_errors <= '0;
        end else if (pll_fail && (pll_errors != 8'hFF)) begin
            pll_errors <= pll_errors + 8'd1;
        end
    end

    // the sequencer must stop advancing at the last table entry
    property p_step_in_table;
        @(posedge clk) disable iff (!reset)
            step <= adv7513_pkg::step_t'(`ADV_TABLE_LEN - 1);
    endproperty

    a_step_in_table: assert property (p_step_in_table)
        else $error("step index %0d is past the end of the table", step);

endmodule

/* init_table.sv */
`timescale 1ns/1ps
`include "adv7513_config.svh"

module init_table (
    input  adv7513_pkg::step_t     step,
    output adv7513_pkg::reg_addr_t reg_addr,
    output adv7513_pkg::reg_data_t value
);

    // upper byte is the register, lower byte the value
    logic [15:0] entry;

    always_comb begin
        case (step)
            // power up all circuits, sync adjust off
            5'd0:  entry = 16'h4110;
            // fixed values required after power up
            5'd1:  entry = 16'h9803;
            5'd2:  entry = 16'h9AE0;
            5'd3:  entry = 16'h9C30;
            5'd4:  entry = 16'h9D01;
            5'd5:  entry = 16'hA2A4;
            5'd6:  entry = 16'hA3A4;
            5'd7:  entry = 16'hE0D0;
            5'd8:  entry = 16'hF900;
            // 44.1 kHz I2S, 24 bit RGB 4:4:4 input with separate syncs
            5'd9:  entry = 16'h1500;
            // 4:4:4 output, 8 bit colour depth
            5'd10: entry = 16'h1630;
            // sync polarity pass through, aspect ratio from the config header
            5'd11: entry = 16'h1700 | {8'h00, `ADV_ASPECT_R};
            // colour space converter off
            5'd12: entry = 16'h1846;
            // HDMI mode, no HDCP
            5'd13: entry = 16'hAF06;
            5'd14: entry = 16'hBA60;
            // automatic CTS, I2S audio
            5'd15: entry = 16'h0A00;
            // audio clock regeneration N = 0x01880
            5'd16: entry = 16'h0100;
            5'd17: entry = 16'h0218;
            5'd18: entry = 16'h0380;
            5'd19: entry = 16'h0B0E;
            // I2S0 only, right justified, 16 bit samples
            5'd20: entry = 16'h0C05;
            5'd21: entry = 16'h0D10;
            // enable HPD and monitor sense interrupts, then clear pending ones
            5'd22: entry = 16'h94C0;
            5'd23: entry = 16'h96C0;
            default: entry = 16'h0000;
        endcase
    end

    assign reg_addr = entry[15:8];
    assign value    = entry[7:0];

endmodule

/* tb_adv7513_init.sv */
`timescale 1ns/1ps
`include "adv7513_config.svh"

module tb_adv7513_init;

    localparam int pass_len = `ADV_TABLE_LEN + 1;
    // five passes of 25 commands at up to 12 cycles of 20 ns take about 30 us
    // the rest is margin for reset, idle time and restarts
    localparam int watchdog_ns = 200_000;

    // the writes of one pass with position 0 in the top bits
    localparam logic [`ADV_TABLE_LEN*16-1:0] table_writes = {
        16'h4110, 16'h9803, 16'h9AE0, 16'h9C30, 16'h9D01, 16'hA2A4, 16'hA3A4, 16'hE0D0,
        16'hF900, 16'h1500, 16'h1630, {8'h17, 8'h00 | `ADV_ASPECT_R}, 16'h1846, 16'hAF06,
        16'hBA60, 16'h0A00,
        16'h0100, 16'h0218, 16'h0380, 16'h0B0E, 16'h0C05, 16'h0D10, 16'h94C0, 16'h96C0
    };

    logic                    clk;
    logic                    reset;
    logic                    hdmi_int;
    logic                    cmd_valid;
    logic                    cmd_is_read;
    adv7513_pkg::chip_addr_t cmd_chip_addr;
    adv7513_pkg::reg_addr_t  cmd_reg_addr;
    adv7513_pkg::reg_data_t  cmd_value;
    logic                    resp_valid;
    adv7513_pkg::reg_data_t  resp_data;
    logic                    resp_ack_error;
    logic                    ready;
    adv7513_pkg::err_count_t pll_errors;

    // engine and chip model state
    logic [7:0] regs [256];
    logic [7:0] lfsr;
    bit         inject_errors = 1'b0;
    int         unlock_reads = 0;
    int         errors_injected = 0;

    // checker state
    int pos = 0;
    int cmd_count = 0;
    int since_resp = 0;
    int ready_due = 0;
    bit outstanding = 1'b0;
    bit gap_known = 1'b0;
    bit locked = 1'b0;
    bit restart_requested = 1'b0;

    adv7513_init_top i_adv7513_init_top (
        .clk            (clk),
        .reset          (reset),
        .hdmi_int       (hdmi_int),
        .cmd_valid      (cmd_valid),
        .cmd_is_read    (cmd_is_read),
        .cmd_chip_addr  (cmd_chip_addr),
        .cmd_reg_addr   (cmd_reg_addr),
        .cmd_value      (cmd_value),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .resp_ack_error (resp_ack_error),
        .ready          (ready),
        .pll_errors     (pll_errors)
    );

    // expected {is_read, reg_addr, value} at a position of one pass
    function automatic logic [16:0] expected_cmd(input int p);
        if (p >= `ADV_TABLE_LEN) begin
            return {1'b1, `ADV_PLL_REG, 8'h00};
        end
        return {1'b0, table_writes[(`ADV_TABLE_LEN - 1 - p) * 16 +: 16]};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] time %0t %s: got 0x%0h, expected 0x%0h",
                                $time, name, actual, expected));
        end
    endtask

    // galois LFSR stepped once per bit taken
    task automatic draw_bits(input int n, output int bits);
        bits = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hB8) : (lfsr >> 1);
            bits = (bits << 1) | lfsr[0];
        end
    endtask

    task automatic wait_ready();
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
    endtask

    // one low cycle on the interrupt line
    task automatic restart_by_interrupt();
        @(negedge clk);
        restart_requested = 1'b1;
        hdmi_int = 1'b0;
        @(negedge clk);
        hdmi_int = 1'b1;
        check_value("ready", ready, 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // engine answers 1 to 8 cycles after cmd_valid
    always begin : engine_model
        int delay;
        int coin;
        @(negedge clk);
        resp_valid = 1'b0;
        if (cmd_valid) begin
            draw_bits(3, delay);
            coin = 1;
            if (inject_errors) begin
                draw_bits(2, coin);
            end
            resp_ack_error = (coin == 0);
            if (resp_ack_error) begin
                errors_injected++;
            end else if (cmd_is_read && cmd_reg_addr == `ADV_PLL_REG) begin
                regs[`ADV_PLL_REG][`ADV_PLL_LOCK_BIT] = (unlock_reads == 0);
                if (unlock_reads > 0) begin
                    unlock_reads--;
                end
            end else if (!cmd_is_read) begin
                regs[cmd_reg_addr] = cmd_value;
            end
            resp_data = regs[cmd_reg_addr];
            repeat (delay) @(negedge clk);
            resp_valid = 1'b1;
        end
    end

    // outputs are sampled on the falling edge and responses on the rising edge
    always begin : compare_commands
        logic [16:0] want;
        @(negedge clk);
        since_resp++;
        if (ready_due > 0) begin
            ready_due--;
            check_value("ready", ready, ready_due == 0);
        end
        if (cmd_valid) begin
            if (outstanding) begin
                abort_run("a second command was issued before the first one was answered");
            end
            if (locked && !restart_requested) begin
                abort_run("a command was issued while ready without an interrupt");
            end
            if (gap_known) begin
                check_value("cycles from resp_valid to cmd_valid", since_resp, 3);
            end
            want = expected_cmd(pos);
            check_value("cmd_chip_addr", cmd_chip_addr, `ADV_CHIP_ADDR);
            check_value("cmd_is_read", cmd_is_read, want[16]);
            check_value("cmd_reg_addr", cmd_reg_addr, want[15:8]);
            if (!want[16]) begin
                check_value("cmd_value", cmd_value, want[7:0]);
            end
            outstanding = 1'b1;
            locked = 1'b0;
            restart_requested = 1'b0;
            cmd_count++;
        end
        @(posedge clk);
        if (resp_valid) begin
            if (!outstanding) begin
                abort_run("the engine answered with no command outstanding");
            end
            outstanding = 1'b0;
            since_resp = 0;
            gap_known = 1'b1;
            if (!resp_ack_error && pos < `ADV_TABLE_LEN) begin
                pos++;
            end else if (!resp_ack_error) begin
                pos = 0;
                if (resp_data[`ADV_PLL_LOCK_BIT]) begin
                    locked = 1'b1;
                    gap_known = 1'b0;
                    ready_due = 2;
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        abort_run("watchdog expired before the tests completed");
    end

    initial begin : run_tests
        int base;
        reset = 1'b0;
        hdmi_int = 1'b1;
        resp_valid = 1'b0;
        resp_data = '0;
        resp_ack_error = 1'b0;
        lfsr = 8'd54;
        for (int a = 0; a < 256; a++) begin
            regs[a] = a[7:0] ^ 8'hA5;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        // single pass with the PLL locked on the first read
        wait_ready();
        check_value("pll_errors", pll_errors, 0);
        check_value("commands in first pass", cmd_count, pass_len);
        repeat (50) @(negedge clk);

        // random acknowledge errors on a pass started by the interrupt
        inject_errors = 1'b1;
        base = cmd_count;
        restart_by_interrupt();
        wait_ready();
        inject_errors = 1'b0;
        if (errors_injected == 0) begin
            abort_run("no acknowledge error was injected during the retry test");
        end
        check_value("commands with retries", cmd_count - base, pass_len + errors_injected);
        check_value("pll_errors", pll_errors, 0);

        // PLL unlocked on the first three reads
        unlock_reads = 3;
        base = cmd_count;
        restart_by_interrupt();
        wait_ready();
        check_value("pll_errors", pll_errors, 3);
        check_value("commands until lock", cmd_count - base, 4 * pass_len);

        $display("Regression passed");
        $finish;
    end

endmodule
